// ==== common/decoder_pkg.sv ====
/* Shared types of the RV32 decode stage. Only the opcodes and AMO codes
   that this stage decodes are listed; everything else decodes as illegal */
package decoder_pkg;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    OPCODE_LOAD  = 7'h03,
    OPCODE_OPIMM = 7'h13,
    OPCODE_AUIPC = 7'h17,
    OPCODE_STORE = 7'h23,
    OPCODE_AMO   = 7'h2f,
    OPCODE_OP    = 7'h33,
    OPCODE_LUI   = 7'h37
  } opcode_e;

  // AMO function codes, instr[31:27]
  typedef enum logic [4:0] {
    AMO_ADD  = 5'b00000,
    AMO_SWAP = 5'b00001,
    AMO_LR   = 5'b00010,
    AMO_SC   = 5'b00011,
    AMO_XOR  = 5'b00100,
    AMO_OR   = 5'b01000,
    AMO_AND  = 5'b01100,
    AMO_MIN  = 5'b10000,
    AMO_MAX  = 5'b10100,
    AMO_MINU = 5'b11000,
    AMO_MAXU = 5'b11100
  } amo_e;

  // LSU access size
  localparam logic [1:0] LSU_WORD = 2'b00;
  localparam logic [1:0] LSU_HALF = 2'b01;
  localparam logic [1:0] LSU_BYTE = 2'b10;

  ////////////////////
  // Operand selects
  ////////////////////

  // OP_A_ZERO doubles as the idle value
  typedef enum logic [1:0] {
    OP_A_REGA_OR_FWD = 2'd0,
    OP_A_PC          = 2'd1,
    OP_A_ZERO        = 2'd2
  } op_a_sel_e;

  typedef enum logic [1:0] {
    OP_B_REGB_OR_FWD = 2'd0,
    OP_B_IMM         = 2'd1,
    OP_B_NONE        = 2'd2
  } op_b_sel_e;

  // Operand C carries store and AMO write data
  typedef enum logic {
    OP_C_REGB_OR_FWD = 1'b0,
    OP_C_NONE        = 1'b1
  } op_c_sel_e;

  typedef enum logic [1:0] {
    IMM_I    = 2'd0,
    IMM_S    = 2'd1,
    IMM_U    = 2'd2,
    IMM_NONE = 2'd3
  } imm_sel_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // Encoded as funct3[1:0] of the MUL group
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

  ////////////////////
  // Records
  ////////////////////

  typedef struct packed {
    logic       illegal_insn;
    logic       alu_en;
    alu_op_e    alu_operator;
    logic       mul_en;
    mul_op_e    mul_operator;
    op_a_sel_e  alu_op_a_mux_sel;
    op_b_sel_e  alu_op_b_mux_sel;
    op_c_sel_e  op_c_mux_sel;
    imm_sel_e   imm_mux_sel;
    // Bit 0 reads rs1, bit 1 reads rs2
    logic [1:0] rf_re;
    logic       rf_we;
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_type;
    logic       lsu_sign_ext;
    // Bit 5 marks an atomic, bits 4..0 hold the AMO code
    logic [5:0] lsu_atop;
  } decoder_ctrl_t;

  // Nothing enabled, every selector idle
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    illegal_insn:     1'b1,
    alu_en:           1'b0,
    alu_operator:     ALU_ADD,
    mul_en:           1'b0,
    mul_operator:     MUL_MUL,
    alu_op_a_mux_sel: OP_A_ZERO,
    alu_op_b_mux_sel: OP_B_NONE,
    op_c_mux_sel:     OP_C_NONE,
    imm_mux_sel:      IMM_NONE,
    rf_re:            2'b00,
    rf_we:            1'b0,
    lsu_en:           1'b0,
    lsu_we:           1'b0,
    lsu_type:         LSU_WORD,
    lsu_sign_ext:     1'b0,
    lsu_atop:         6'b000000
  };

  // Record handed to the execute stage
  typedef struct packed {
    logic          valid;
    decoder_ctrl_t ctrl;
    logic [4:0]    rs1_addr;
    logic [4:0]    rs2_addr;
    logic [4:0]    rd_addr;
    logic [31:0]   imm;
  } id_ex_t;

endpackage

// ==== decoder/a_decoder.sv ====
/* Word-size AMOs only (funct3 010); the aq/rl bits are not decoded here
   and are left to the LSU */
module a_decoder import decoder_pkg::*; (
  input  logic [31:0]   instr_rdata_i,
  output decoder_ctrl_t decoder_ctrl_o
);

  // Fields of the AMO format
  opcode_e    opcode;
  logic [2:0] funct3;
  amo_e       funct5;
  logic [4:0] rs2;
  logic       illegal;

  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  assign funct3 = instr_rdata_i[14:12];
  assign funct5 = amo_e'(instr_rdata_i[31:27]);
  assign rs2    = instr_rdata_i[24:20];

  always_comb begin
    // Controls shared by every word AMO
    decoder_ctrl_o                  = DECODER_CTRL_ILLEGAL_INSN;
    decoder_ctrl_o.illegal_insn     = 1'b0;
    decoder_ctrl_o.lsu_en           = 1'b1;
    decoder_ctrl_o.lsu_type         = LSU_WORD;
    decoder_ctrl_o.lsu_sign_ext     = 1'b1;
    decoder_ctrl_o.rf_re[0]         = 1'b1;
    decoder_ctrl_o.rf_we            = 1'b1;
    // Address comes straight from rs1, no offset
    decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
    decoder_ctrl_o.lsu_atop         = {1'b1, funct5};

    // Doubleword and other widths are not ours
    illegal = (opcode != OPCODE_AMO) || (funct3 != 3'b010);

    case (funct5)
      AMO_LR: begin
        // No write data; rs2 field is reserved and must be zero
        illegal = illegal || (rs2 != 5'd0);
      end
      AMO_SC, AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR,
      AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU: begin
        // rs2 is the store data, routed as operand C
        decoder_ctrl_o.rf_re[1]     = 1'b1;
        decoder_ctrl_o.op_c_mux_sel = OP_C_REGB_OR_FWD;
        decoder_ctrl_o.lsu_we       = 1'b1;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // Unclaimed words leave as the illegal constant
    if (illegal) begin
      decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
    end
  end

endmodule

// ==== decoder/i_decoder.sv ====
/* Base integer subset only: loads, stores, OP, OP-IMM, LUI, AUIPC.
   OP words with funct7 0000001 are left to the multiply decoder */
module i_decoder import decoder_pkg::*; (
  input  logic [31:0]   instr_rdata_i,
  output decoder_ctrl_t decoder_ctrl_o
);

  // funct7 values of the base set
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;

  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  always_comb begin
    decoder_ctrl_o              = DECODER_CTRL_ILLEGAL_INSN;
    decoder_ctrl_o.illegal_insn = 1'b0;
    illegal                     = 1'b0;

    case (opcode)
      OPCODE_LOAD: begin
        // rs1 + I immediate
        decoder_ctrl_o.lsu_en           = 1'b1;
        decoder_ctrl_o.rf_re[0]         = 1'b1;
        decoder_ctrl_o.rf_we            = 1'b1;
        decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.imm_mux_sel      = IMM_I;
        // Size from funct3[1:0], funct3[2] selects zero extension
        decoder_ctrl_o.lsu_sign_ext     = !funct3[2];
        case (funct3)
          3'b000, 3'b100: decoder_ctrl_o.lsu_type = LSU_BYTE;
          3'b001, 3'b101: decoder_ctrl_o.lsu_type = LSU_HALF;
          3'b010:         decoder_ctrl_o.lsu_type = LSU_WORD;
          default:        illegal = 1'b1;
        endcase
      end

      OPCODE_STORE: begin
        // rs1 + S immediate, rs2 as write data
        decoder_ctrl_o.lsu_en           = 1'b1;
        decoder_ctrl_o.lsu_we           = 1'b1;
        decoder_ctrl_o.rf_re            = 2'b11;
        decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.op_c_mux_sel     = OP_C_REGB_OR_FWD;
        decoder_ctrl_o.imm_mux_sel      = IMM_S;
        case (funct3)
          3'b000:  decoder_ctrl_o.lsu_type = LSU_BYTE;
          3'b001:  decoder_ctrl_o.lsu_type = LSU_HALF;
          3'b010:  decoder_ctrl_o.lsu_type = LSU_WORD;
          default: illegal = 1'b1;
        endcase
      end

      OPCODE_OPIMM: begin
        decoder_ctrl_o.alu_en           = 1'b1;
        decoder_ctrl_o.rf_re[0]         = 1'b1;
        decoder_ctrl_o.rf_we            = 1'b1;
        decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.imm_mux_sel      = IMM_I;
        case (funct3)
          3'b000: decoder_ctrl_o.alu_operator = ALU_ADD;
          3'b010: decoder_ctrl_o.alu_operator = ALU_SLT;
          3'b011: decoder_ctrl_o.alu_operator = ALU_SLTU;
          3'b100: decoder_ctrl_o.alu_operator = ALU_XOR;
          3'b110: decoder_ctrl_o.alu_operator = ALU_OR;
          3'b111: decoder_ctrl_o.alu_operator = ALU_AND;
          3'b001: begin
            // Shift amount in imm[4:0], upper bits fixed
            decoder_ctrl_o.alu_operator = ALU_SLL;
            illegal = (funct7 != FUNCT7_BASE);
          end
          default: begin
            // funct3 101, logical or arithmetic right shift
            if (funct7 == FUNCT7_BASE) begin
              decoder_ctrl_o.alu_operator = ALU_SRL;
            end else if (funct7 == FUNCT7_ALT) begin
              decoder_ctrl_o.alu_operator = ALU_SRA;
            end else begin
              illegal = 1'b1;
            end
          end
        endcase
      end

      OPCODE_OP: begin
        decoder_ctrl_o.alu_en           = 1'b1;
        decoder_ctrl_o.rf_re            = 2'b11;
        decoder_ctrl_o.rf_we            = 1'b1;
        decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_REGB_OR_FWD;
        case ({funct7, funct3})
          {FUNCT7_BASE, 3'b000}: decoder_ctrl_o.alu_operator = ALU_ADD;
          {FUNCT7_BASE, 3'b001}: decoder_ctrl_o.alu_operator = ALU_SLL;
          {FUNCT7_BASE, 3'b010}: decoder_ctrl_o.alu_operator = ALU_SLT;
          {FUNCT7_BASE, 3'b011}: decoder_ctrl_o.alu_operator = ALU_SLTU;
          {FUNCT7_BASE, 3'b100}: decoder_ctrl_o.alu_operator = ALU_XOR;
          {FUNCT7_BASE, 3'b101}: decoder_ctrl_o.alu_operator = ALU_SRL;
          {FUNCT7_BASE, 3'b110}: decoder_ctrl_o.alu_operator = ALU_OR;
          {FUNCT7_BASE, 3'b111}: decoder_ctrl_o.alu_operator = ALU_AND;
          {FUNCT7_ALT,  3'b000}: decoder_ctrl_o.alu_operator = ALU_SUB;
          {FUNCT7_ALT,  3'b101}: decoder_ctrl_o.alu_operator = ALU_SRA;
          // MUL group and unknown funct7 fall here
          default:               illegal = 1'b1;
        endcase
      end

      OPCODE_LUI, OPCODE_AUIPC: begin
        // U immediate added to zero or to the PC
        decoder_ctrl_o.alu_en           = 1'b1;
        decoder_ctrl_o.rf_we            = 1'b1;
        decoder_ctrl_o.alu_operator     = ALU_ADD;
        decoder_ctrl_o.alu_op_a_mux_sel = (opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_PC;
        decoder_ctrl_o.alu_op_b_mux_sel = OP_B_IMM;
        decoder_ctrl_o.imm_mux_sel      = IMM_U;
      end

      default: begin
        illegal = 1'b1;
      end
    endcase

    if (illegal) begin
      decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
    end
  end

endmodule

// ==== decoder/m_decoder.sv ====
/* MUL group of RV32M only; the division encodings stay unclaimed */
module m_decoder import decoder_pkg::*; (
  input  logic [31:0]   instr_rdata_i,
  output decoder_ctrl_t decoder_ctrl_o
);

  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       claim;

  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  // funct3[2] set is DIV/DIVU/REM/REMU
  assign claim = (opcode == OPCODE_OP) && (funct7 == FUNCT7_MULDIV) && !funct3[2];

  always_comb begin
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
    if (claim) begin
      decoder_ctrl_o.illegal_insn     = 1'b0;
      decoder_ctrl_o.mul_en           = 1'b1;
      decoder_ctrl_o.rf_re            = 2'b11;
      decoder_ctrl_o.rf_we            = 1'b1;
      decoder_ctrl_o.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
      decoder_ctrl_o.alu_op_b_mux_sel = OP_B_REGB_OR_FWD;
      // Signedness of the high half per funct3
      case (funct3[1:0])
        2'b00:   decoder_ctrl_o.mul_operator = MUL_MUL;
        2'b01:   decoder_ctrl_o.mul_operator = MUL_MULH;
        2'b10:   decoder_ctrl_o.mul_operator = MUL_MULHSU;
        default: decoder_ctrl_o.mul_operator = MUL_MULHU;
      endcase
    end
  end

endmodule

// ==== decoder/id_decoder.sv ====
/* Purely combinational. The sub-decoders are expected to claim disjoint
   encodings; an overlap is flagged by a deferred check */
module id_decoder import decoder_pkg::*; (
  input  logic [31:0]   instr_rdata_i,
  output decoder_ctrl_t decoder_ctrl_o
);

  decoder_ctrl_t a_ctrl;
  decoder_ctrl_t i_ctrl;
  decoder_ctrl_t m_ctrl;

  // A sub-decoder claims a word by clearing illegal_insn
  logic a_claim;
  logic i_claim;
  logic m_claim;

  ////////////////////
  // Sub-decoders
  ////////////////////

  a_decoder i_a_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (a_ctrl)
  );

  i_decoder i_i_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (i_ctrl)
  );

  m_decoder i_m_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (m_ctrl)
  );

  assign a_claim = !a_ctrl.illegal_insn;
  assign i_claim = !i_ctrl.illegal_insn;
  assign m_claim = !m_ctrl.illegal_insn;

  ////////////////////
  // Merge
  ////////////////////

  always_comb begin
    // Nobody claims it, so it is illegal
    decoder_ctrl_o = DECODER_CTRL_ILLEGAL_INSN;
    if (a_claim) begin
      decoder_ctrl_o = a_ctrl;
    end else if (i_claim) begin
      decoder_ctrl_o = i_ctrl;
    end else if (m_claim) begin
      decoder_ctrl_o = m_ctrl;
    end

    // Ownership split between the three decoders must not overlap
    assert final ($onehot0({a_claim, i_claim, m_claim}))
      else $error("more than one sub-decoder claims instr %h", instr_rdata_i);
  end

endmodule

// ==== hdl/id_stage.sv ====
/* One-instruction decode stage, one cycle of latency. halt_i freezes the
   whole output record; upstream must hold the instruction meanwhile */
module id_stage import decoder_pkg::*; (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        halt_i,
  output id_ex_t      id_ex_o
);

  decoder_ctrl_t decoder_ctrl;
  logic [31:0]   imm;
  id_ex_t        id_ex_d;

  id_decoder i_id_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (decoder_ctrl)
  );

  // Immediate formats, all sign-extended from bit 31 except U
  always_comb begin
    case (decoder_ctrl.imm_mux_sel)
      IMM_I:   imm = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
      IMM_S:   imm = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
      IMM_U:   imm = {instr_rdata_i[31:12], 12'h000};
      default: imm = 32'h0000_0000;
    endcase
  end

  // Register fields pass through even for illegal words
  assign id_ex_d = '{
    valid:    instr_valid_i,
    ctrl:     decoder_ctrl,
    rs1_addr: instr_rdata_i[19:15],
    rs2_addr: instr_rdata_i[24:20],
    rd_addr:  instr_rdata_i[11:7],
    imm:      imm
  };

  ////////////////////
  // ID/EX register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      id_ex_o <= '{valid: 1'b0, ctrl: DECODER_CTRL_ILLEGAL_INSN, default: '0};
    end else if (!halt_i) begin
      id_ex_o <= id_ex_d;
    end
  end

  // Halt holds the record across the edge
  a_halt_hold : assert property (@(posedge clk) disable iff (rst_i)
    halt_i |=> $stable(id_ex_o));

  // Memory and multiplier are never started by the same instruction
  a_lsu_mul_excl : assert property (@(posedge clk) disable iff (rst_i)
    id_ex_o.valid |-> !(id_ex_o.ctrl.lsu_en && id_ex_o.ctrl.mul_en));

  // Illegal records start no unit and write no register
  a_illegal_quiet : assert property (@(posedge clk) disable iff (rst_i)
    id_ex_o.ctrl.illegal_insn |-> !(id_ex_o.ctrl.alu_en || id_ex_o.ctrl.mul_en ||
      id_ex_o.ctrl.lsu_en || id_ex_o.ctrl.lsu_we || id_ex_o.ctrl.rf_we));

endmodule

// ==== bench/tb_id_stage.sv ====
/* Checks id_stage against a reference decode of its own. Inputs change 2 time
   units after the rising edge and outputs are read at that same point */
module tb_id_stage import decoder_pkg::*; ();

  localparam int CLK_PERIOD      = 20;
  localparam int RANDOM_WORDS    = 200;
  // Upper bound on the words the directed tests apply
  localparam int DIRECTED_WORDS  = 100;
  localparam int WATCHDOG_CYCLES = (DIRECTED_WORDS + RANDOM_WORDS) * 40;

  logic        clk;
  logic        rst_i;
  logic        instr_valid_i;
  logic [31:0] instr_rdata_i;
  logic        halt_i;
  id_ex_t      id_ex_o;

  integer seed         = 32'hf994f152;
  int     err_count    = 0;
  int     err_at_start = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;

  amo_e    amo_codes [0:10] = '{AMO_LR, AMO_SC, AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND,
                                AMO_OR, AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};
  // Opcode pool for the random words
  opcode_e rand_ops [0:6]   = '{OPCODE_LOAD, OPCODE_STORE, OPCODE_OP, OPCODE_OPIMM,
                                OPCODE_LUI, OPCODE_AUIPC, OPCODE_AMO};

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  id_stage i_id_stage (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_valid_i (instr_valid_i),
    .instr_rdata_i (instr_rdata_i),
    .halt_i        (halt_i),
    .id_ex_o       (id_ex_o)
  );

  ////////////////////
  // Reference decode
  ////////////////////

  function automatic alu_op_e ref_alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Word-size AMO function codes of the A extension
  function automatic logic amo_known(input logic [4:0] f5);
    return f5 inside {5'h00, 5'h01, 5'h02, 5'h03, 5'h04, 5'h08,
                      5'h0c, 5'h10, 5'h14, 5'h18, 5'h1c};
  endfunction

  function automatic decoder_ctrl_t ref_decode(input logic [31:0] w);
    decoder_ctrl_t c;
    logic [2:0]    f3;
    logic [6:0]    f7;
    logic [4:0]    f5;
    logic          legal;
    f3    = w[14:12];
    f7    = w[31:25];
    f5    = w[31:27];
    c     = DECODER_CTRL_ILLEGAL_INSN;
    legal = 1'b0;
    case (w[6:0])
      OPCODE_LOAD: begin
        legal              = !(f3 == 3'b011 || f3 > 3'b101);
        c.lsu_en           = 1'b1;
        c.rf_re            = 2'b01;
        c.rf_we            = 1'b1;
        c.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        c.alu_op_b_mux_sel = OP_B_IMM;
        c.imm_mux_sel      = IMM_I;
        // 00 word, 01 half, 10 byte
        c.lsu_type         = (f3[1:0] == 2'b00) ? 2'b10 : (f3[1:0] == 2'b01) ? 2'b01 : 2'b00;
        c.lsu_sign_ext     = !f3[2];
      end
      OPCODE_STORE: begin
        legal              = (f3 <= 3'b010);
        c.lsu_en           = 1'b1;
        c.lsu_we           = 1'b1;
        c.rf_re            = 2'b11;
        c.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        c.alu_op_b_mux_sel = OP_B_IMM;
        c.op_c_mux_sel     = OP_C_REGB_OR_FWD;
        c.imm_mux_sel      = IMM_S;
        c.lsu_type         = (f3[1:0] == 2'b00) ? 2'b10 : (f3[1:0] == 2'b01) ? 2'b01 : 2'b00;
      end
      OPCODE_OPIMM: begin
        // Shift immediates carry a funct7 in imm[11:5]
        legal = (f3 == 3'b001) ? (f7 == 7'h00) :
                (f3 == 3'b101) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        c.alu_en           = 1'b1;
        c.alu_operator     = ref_alu_op(f3, f3 == 3'b101 && f7 == 7'h20);
        c.rf_re            = 2'b01;
        c.rf_we            = 1'b1;
        c.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        c.alu_op_b_mux_sel = OP_B_IMM;
        c.imm_mux_sel      = IMM_I;
      end
      OPCODE_OP: begin
        c.rf_re            = 2'b11;
        c.rf_we            = 1'b1;
        c.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        c.alu_op_b_mux_sel = OP_B_REGB_OR_FWD;
        if (f7 == 7'h01) begin
          // MUL group only, division stays illegal
          legal  = !f3[2];
          c.mul_en = 1'b1;
          case (f3[1:0])
            2'b00:   c.mul_operator = MUL_MUL;
            2'b01:   c.mul_operator = MUL_MULH;
            2'b10:   c.mul_operator = MUL_MULHSU;
            default: c.mul_operator = MUL_MULHU;
          endcase
        end else begin
          legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
          c.alu_en       = 1'b1;
          c.alu_operator = ref_alu_op(f3, f7 == 7'h20);
        end
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        legal              = 1'b1;
        c.alu_en           = 1'b1;
        c.rf_we            = 1'b1;
        c.alu_operator     = ALU_ADD;
        c.alu_op_a_mux_sel = (w[6:0] == OPCODE_LUI) ? OP_A_ZERO : OP_A_PC;
        c.alu_op_b_mux_sel = OP_B_IMM;
        c.imm_mux_sel      = IMM_U;
      end
      OPCODE_AMO: begin
        // LR needs rs2 zero
        legal = (f3 == 3'b010) && amo_known(f5) && (f5 != 5'h02 || w[24:20] == 5'd0);
        c.lsu_en           = 1'b1;
        c.lsu_type         = 2'b00;
        c.lsu_sign_ext     = 1'b1;
        c.rf_re            = 2'b01;
        c.rf_we            = 1'b1;
        c.alu_op_a_mux_sel = OP_A_REGA_OR_FWD;
        c.lsu_atop         = {1'b1, f5};
        if (f5 != 5'h02) begin
          c.rf_re[1]     = 1'b1;
          c.op_c_mux_sel = OP_C_REGB_OR_FWD;
          c.lsu_we       = 1'b1;
        end
      end
      default: legal = 1'b0;
    endcase
    if (legal) begin
      c.illegal_insn = 1'b0;
    end else begin
      c = DECODER_CTRL_ILLEGAL_INSN;
    end
    return c;
  endfunction

  function automatic logic [31:0] ref_imm(input logic [31:0] w, input imm_sel_e sel);
    case (sel)
      IMM_I:   return {{20{w[31]}}, w[31:20]};
      IMM_S:   return {{20{w[31]}}, w[31:25], w[11:7]};
      IMM_U:   return {w[31:12], 12'h000};
      default: return 32'h0;
    endcase
  endfunction

  function automatic id_ex_t ref_record(input logic [31:0] w, input logic v);
    id_ex_t r;
    r.valid    = v;
    r.ctrl     = ref_decode(w);
    r.rs1_addr = w[19:15];
    r.rs2_addr = w[24:20];
    r.rd_addr  = w[11:7];
    r.imm      = ref_imm(w, r.ctrl.imm_mux_sel);
    return r;
  endfunction

  ////////////////////
  // Encoders
  ////////////////////

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_ctrl(input string name, input decoder_ctrl_t exp, input decoder_ctrl_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_addr(input string name, input logic [4:0] exp, input logic [4:0] act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_record(input id_ex_t exp);
    check_bit("id_ex_o.valid", exp.valid, id_ex_o.valid);
    check_ctrl("id_ex_o.ctrl", exp.ctrl, id_ex_o.ctrl);
    check_addr("id_ex_o.rs1_addr", exp.rs1_addr, id_ex_o.rs1_addr);
    check_addr("id_ex_o.rs2_addr", exp.rs2_addr, id_ex_o.rs2_addr);
    check_addr("id_ex_o.rd_addr", exp.rd_addr, id_ex_o.rd_addr);
    check_word("id_ex_o.imm", exp.imm, id_ex_o.imm);
  endtask

  ////////////////////
  // Drivers
  ////////////////////

  // Leaves time at 2 units past the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_word(input logic [31:0] w);
    instr_rdata_i = w;
    instr_valid_i = 1'b1;
    next_cycle();
    check_record(ref_record(w, 1'b1));
  endtask

  // Also compares against the illegal constant directly
  task automatic apply_illegal(input logic [31:0] w);
    apply_word(w);
    check_ctrl("id_ex_o.ctrl", DECODER_CTRL_ILLEGAL_INSN, id_ex_o.ctrl);
  endtask

  task automatic begin_test();
    err_at_start = err_count;
  endtask

  task automatic end_test(input string name);
    if (err_count == err_at_start) begin
      tests_passed++;
      $display("[pass] %s", name);
    end else begin
      tests_failed++;
      $display("[fail] %s, %0d mismatches", name, err_count - err_at_start);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_reset();
    begin_test();
    check_bit("id_ex_o.valid", 1'b0, id_ex_o.valid);
    check_ctrl("id_ex_o.ctrl", DECODER_CTRL_ILLEGAL_INSN, id_ex_o.ctrl);
    check_addr("id_ex_o.rs1_addr", 5'd0, id_ex_o.rs1_addr);
    check_addr("id_ex_o.rs2_addr", 5'd0, id_ex_o.rs2_addr);
    check_addr("id_ex_o.rd_addr", 5'd0, id_ex_o.rd_addr);
    check_word("id_ex_o.imm", 32'h0, id_ex_o.imm);
    end_test("reset");
  endtask

  task automatic test_amo_all();
    logic [4:0] f5;
    logic [4:0] rs2;
    begin_test();
    for (int i = 0; i < 11; i++) begin
      f5  = amo_codes[i];
      rs2 = (f5 == AMO_LR) ? 5'd0 : 5'(i + 3);
      apply_word({f5, 2'b01, rs2, 5'(i + 10), 3'b010, 5'(i + 1), OPCODE_AMO});
      // LR writes no memory and reads no rs2
      check_bit("id_ex_o.ctrl.lsu_we", f5 != AMO_LR, id_ex_o.ctrl.lsu_we);
      check_bit("id_ex_o.ctrl.rf_re[1]", f5 != AMO_LR, id_ex_o.ctrl.rf_re[1]);
    end
    end_test("amo_all");
  endtask

  task automatic test_amo_reject();
    begin_test();
    // Doubleword and byte widths
    apply_illegal({AMO_SWAP, 2'b00, 5'd4, 5'd5, 3'b011, 5'd6, OPCODE_AMO});
    apply_illegal({AMO_ADD, 2'b00, 5'd4, 5'd5, 3'b000, 5'd6, OPCODE_AMO});
    apply_illegal({AMO_LR, 2'b00, 5'd7, 5'd5, 3'b010, 5'd6, OPCODE_AMO});
    // Unused function codes
    apply_illegal({5'b00101, 2'b00, 5'd4, 5'd5, 3'b010, 5'd6, OPCODE_AMO});
    apply_illegal({5'b01010, 2'b00, 5'd4, 5'd5, 3'b010, 5'd6, OPCODE_AMO});
    apply_illegal({5'b11111, 2'b00, 5'd4, 5'd5, 3'b010, 5'd6, OPCODE_AMO});
    end_test("amo_reject");
  endtask

  task automatic test_base();
    logic [2:0]  f3;
    logic [11:0] imm;
    begin_test();
    for (int f = 0; f < 8; f++) begin
      f3 = 3'(f);
      // Negative offsets, -100 for loads and -16 for stores
      if (f3 == 3'b011 || f3 > 3'b101) begin
        apply_illegal(enc_i(12'hf9c, 5'd2, f3, 5'd8, OPCODE_LOAD));
      end else begin
        apply_word(enc_i(12'hf9c, 5'd2, f3, 5'd8, OPCODE_LOAD));
      end
      apply_word(enc_s(12'hff0, 5'd9, 5'd3, f3));
    end
    apply_word(enc_i(12'h07f, 5'd1, 3'b010, 5'd31, OPCODE_LOAD));
    apply_word(enc_s(12'h123, 5'd17, 5'd18, 3'b010));
    for (int f = 0; f < 8; f++) begin
      f3  = 3'(f);
      imm = (f3 == 3'b001 || f3 == 3'b101) ? {7'h00, 5'd13} : 12'h801;
      apply_word(enc_i(imm, 5'd4, f3, 5'd5, OPCODE_OPIMM));
      apply_word(enc_r(7'h00, 5'd11, 5'd12, f3, 5'd13, OPCODE_OP));
    end
    apply_word(enc_i({7'h20, 5'd31}, 5'd6, 3'b101, 5'd7, OPCODE_OPIMM));
    apply_illegal(enc_i({7'h20, 5'd1}, 5'd6, 3'b001, 5'd7, OPCODE_OPIMM));
    apply_word(enc_r(7'h20, 5'd14, 5'd15, 3'b000, 5'd16, OPCODE_OP));
    apply_word(enc_r(7'h20, 5'd14, 5'd15, 3'b101, 5'd16, OPCODE_OP));
    apply_word({20'hdead0, 5'd9, OPCODE_LUI});
    apply_word({20'h80001, 5'd10, OPCODE_AUIPC});
    end_test("base_integer");
  endtask

  task automatic test_mul();
    begin_test();
    for (int f = 0; f < 4; f++) begin
      apply_word(enc_r(7'h01, 5'd21, 5'd22, 3'(f), 5'd23, OPCODE_OP));
      check_bit("id_ex_o.ctrl.mul_en", 1'b1, id_ex_o.ctrl.mul_en);
    end
    // DIV, DIVU, REM, REMU
    for (int f = 4; f < 8; f++) begin
      apply_illegal(enc_r(7'h01, 5'd21, 5'd22, 3'(f), 5'd23, OPCODE_OP));
    end
    apply_illegal(enc_r(7'h04, 5'd21, 5'd22, 3'b000, 5'd23, OPCODE_OP));
    end_test("multiply");
  endtask

  task automatic test_stage_timing();
    logic [31:0] w;
    id_ex_t      held;
    begin_test();
    // Valid low still carries the decode
    w             = enc_i(12'h010, 5'd1, 3'b000, 5'd2, OPCODE_OPIMM);
    instr_rdata_i = w;
    instr_valid_i = 1'b0;
    next_cycle();
    check_record(ref_record(w, 1'b0));
    w = enc_s(12'h7fc, 5'd5, 5'd6, 3'b001);
    apply_word(w);
    held = ref_record(w, 1'b1);
    // Input keeps changing while halted
    halt_i = 1'b1;
    for (int k = 0; k < 3; k++) begin
      w             = enc_r(7'h01, 5'(k), 5'(k + 8), 3'(k), 5'(k + 16), OPCODE_OP);
      instr_rdata_i = w;
      next_cycle();
      check_record(held);
    end
    halt_i = 1'b0;
    next_cycle();
    check_record(ref_record(w, 1'b1));
    end_test("stage_timing");
  endtask

  task automatic test_random();
    logic [31:0] r;
    int          idx;
    begin_test();
    for (int n = 0; n < RANDOM_WORDS; n++) begin
      r   = $random(seed);
      idx = $unsigned($random(seed)) % 7;
      apply_word({r[31:7], rand_ops[idx]});
    end
    end_test("random_words");
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_rdata_i = 32'h0;
    halt_i        = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst_i = 1'b0;

    test_reset();
    test_amo_all();
    test_amo_reject();
    test_base();
    test_mul();
    test_stage_timing();
    test_random();

    $display("Summary: %0d tests passed, %0d tests failed, %0d mismatches",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Bound of about 40 cycles per applied word
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
common/decoder_pkg.sv
decoder/a_decoder.sv
decoder/i_decoder.sv
decoder/m_decoder.sv
decoder/id_decoder.sv
hdl/id_stage.sv
bench/tb_id_stage.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) -o V$(TOP)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@! grep -q "Test FAILED" $(LOG)

check: run
	@grep -q "Test OK" $(LOG) || (echo "No pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
